//--- verilog/mipsPkg.sv
// Shared widths, instruction encodings and bus-side structs for the CPU
// Imported by every RTL module that needs a type from here
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // Primary opcodes still supported
    typedef enum logic [5:0] {
        opRType = 6'd0,
        opJ     = 6'd2,
        opBeq   = 6'd4,
        opBne   = 6'd5,
        opAddiu = 6'd9,
        opSlti  = 6'd10,
        opSltiu = 6'd11,
        opAndi  = 6'd12,
        opOri   = 6'd13,
        opXori  = 6'd14,
        opLui   = 6'd15,
        opLb    = 6'd32,
        opLw    = 6'd35,
        opLbu   = 6'd36,
        opSb    = 6'd40,
        opSw    = 6'd43
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    // Low half is either rd/shamt/funct or the 16-bit immediate
    typedef struct packed {
        opcode_t opcode;
        regAddr_t rs;
        regAddr_t rt;
        union packed {
            struct packed {
                regAddr_t rd;
                logic [4:0] shamt;
                funct_t funct;
            } r;
            logic [15:0] immediate;
        } low;
    } instrFields_t;

    typedef struct packed {
        logic isByte;          // LB, LBU, SB
        logic isUnsigned;      // LBU only
        logic [1:0] byteOffset; // Low address bits
    } memAccess_t;

endpackage

`default_nettype wire

//--- verilog/registerFile.sv
// 32-entry general register file, two combinational reads, one write
// Register 2 is brought out for observation
`timescale 1ns/1ps
`default_nettype none

module registerFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rsIndex,
    input  regAddr_t rtIndex,
    input  logic     writeEnable,
    input  regAddr_t writeIndex,
    input  word_t    writeData,
    output word_t    rsData,
    output word_t    rtData,
    output word_t    registerV0
);

    word_t regs [0:2**regAddrWidth-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIndex != '0)) begin
            regs[writeIndex] <= writeData; // $zero never written
        end
    end

    assign rsData = regs[rsIndex];
    assign rtData = regs[rtIndex];
    assign registerV0 = regs[2]; // $v0

endmodule

`default_nettype wire

//--- verilog/mipsAlu.sv
// Combinational ALU for arithmetic, logic, compare and shift operations
// equal compares the raw operands for BEQ/BNE
`timescale 1ns/1ps
`default_nettype none

module mipsAlu import mipsPkg::*; (
    input  aluOp_t     aluOp,
    input  word_t      operandA,
    input  word_t      operandB,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       equal
);

    logic lessSigned, lessUnsigned;

    assign lessSigned = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;
    assign equal = (operandA == operandB);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = operandA + operandB; // No overflow trap
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluXor: begin
                result = operandA ^ operandB;
            end
            aluSlt: begin
                result = {{(dataWidth-1){1'b0}}, lessSigned};
            end
            aluSltu: begin
                result = {{(dataWidth-1){1'b0}}, lessUnsigned};
            end
            // Shifts take the rt operand and the instruction shamt
            aluSll: begin
                result = operandB << shamt;
            end
            aluSrl: begin
                result = operandB >> shamt;
            end
            aluSra: begin
                result = word_t'($signed(operandB) >>> shamt);
            end
            aluLui: begin
                result = {operandB[15:0], 16'b0}; // Zero-extended immediate moved up
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/loadStoreUnit.sv
// Byte lane steering for stores and byte extraction for loads
// Little endian, lane 0 holds the byte at offset 0
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit import mipsPkg::*; (
    input  memAccess_t access,
    input  word_t      storeData,
    input  word_t      readData,
    output word_t      writeData,
    output logic [3:0] byteEnable,
    output word_t      loadValue
);

    logic [7:0] loadByte;

    // Stores
    always_comb begin
        if (access.isByte) begin
            writeData = {4{storeData[7:0]}}; // Same byte on every lane
            byteEnable = 4'b0001 << access.byteOffset;
        end else begin
            writeData = storeData;
            byteEnable = 4'b1111;
        end
    end

    // Loads
    assign loadByte = readData[8*access.byteOffset +: 8];

    always_comb begin
        if (!access.isByte) begin
            loadValue = readData; // LW
        end else if (access.isUnsigned) begin
            loadValue = {24'b0, loadByte};
        end else begin
            loadValue = {{24{loadByte[7]}}, loadByte};
        end
    end

endmodule

`default_nettype wire

//--- verilog/cpuControl.sv
// Sequencer of the CPU: FSM, PC, delay slot, decode and bus strobes
// Fetch, execute and optional memory phase per instruction
`timescale 1ns/1ps
`default_nettype none

module cpuControl import mipsPkg::*; #(
    parameter word_t resetVector = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       waitRequest,
    input  word_t      readData,
    input  word_t      rsData,
    input  word_t      rtData,
    input  word_t      aluResult,
    input  logic       equal,
    input  word_t      loadValue,
    output regAddr_t   rsIndex,
    output regAddr_t   rtIndex,
    output logic       regWrite,
    output regAddr_t   regWriteIndex,
    output word_t      regWriteData,
    output aluOp_t     aluOp,
    output word_t      aluOperandB,
    output logic [4:0] shamt,
    output memAccess_t access,
    output word_t      address,
    output logic       read,
    output logic       write,
    output logic       active
);

    typedef enum logic [1:0] {stFetch, stExecute, stMemory, stHalt} state_t;

    state_t state;
    word_t pc, instrReg, memAddr, pendingTarget;
    logic branchPending; // Next PC update goes to pendingTarget
    logic started;       // Holds the bus idle in the first cycle out of reset
    instrFields_t fields;
    word_t pcPlus4, nextPc, extImm, branchTarget, jumpTarget, target;
    logic useImm, signExt, writesReg, isLoad, isStore, takeBranch;

    assign fields = instrReg;
    assign pcPlus4 = pc + 32'd4; // Delay-slot address
    assign nextPc = branchPending ? pendingTarget : pcPlus4;
    assign extImm = signExt ? {{16{fields.low.immediate[15]}}, fields.low.immediate}
                            : {16'b0, fields.low.immediate};
    assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};
    assign jumpTarget = {pcPlus4[31:28], instrReg[25:0], 2'b00}; // 26-bit index

    // Decode
    always_comb begin
        aluOp = aluAdd; // Also address calc for loads and stores
        useImm = 1'b1;
        signExt = 1'b1;
        writesReg = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        takeBranch = 1'b0;
        target = branchTarget;
        regWriteIndex = fields.rt;
        case (fields.opcode)
            opRType: begin
                useImm = 1'b0;
                writesReg = 1'b1;
                regWriteIndex = fields.low.r.rd;
                case (fields.low.r.funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnSll:  aluOp = aluSll;
                    fnSrl:  aluOp = aluSrl;
                    fnSra:  aluOp = aluSra;
                    fnJr: begin
                        writesReg = 1'b0;
                        takeBranch = 1'b1;
                        target = rsData;
                    end
                    default: writesReg = 1'b0; // Unknown funct is a no-op
                endcase
            end
            opJ: begin
                takeBranch = 1'b1;
                target = jumpTarget;
            end
            opBeq: begin
                useImm = 1'b0; // Compare rs with rt
                aluOp = aluSub;
                takeBranch = equal;
            end
            opBne: begin
                useImm = 1'b0;
                aluOp = aluSub;
                takeBranch = !equal;
            end
            opAddiu: writesReg = 1'b1;
            opSlti: begin
                aluOp = aluSlt;
                writesReg = 1'b1;
            end
            opSltiu: begin
                aluOp = aluSltu; // Immediate still sign-extended
                writesReg = 1'b1;
            end
            opAndi, opOri, opXori: begin
                signExt = 1'b0;
                writesReg = 1'b1;
                aluOp = (fields.opcode == opAndi) ? aluAnd :
                        (fields.opcode == opOri) ? aluOr : aluXor;
            end
            opLui: begin
                aluOp = aluLui;
                signExt = 1'b0;
                writesReg = 1'b1;
            end
            opLb, opLbu, opLw: isLoad = 1'b1;
            opSb, opSw: isStore = 1'b1;
            default: ; // Unknown opcode is a no-op
        endcase
    end

    assign rsIndex = fields.rs;
    assign rtIndex = fields.rt;
    assign shamt = fields.low.r.shamt;
    assign aluOperandB = useImm ? extImm : rtData;

    assign access.isByte = (fields.opcode == opLb) || (fields.opcode == opLbu)
                        || (fields.opcode == opSb);
    assign access.isUnsigned = (fields.opcode == opLbu);
    assign access.byteOffset = memAddr[1:0];

    // Bus strobes, address is PC except in the memory phase
    assign address = (state == stMemory) ? memAddr : pc;
    assign read = started && (((state == stFetch) && (pc != '0))
                           || ((state == stMemory) && isLoad));
    assign write = (state == stMemory) && isStore;
    assign active = (state != stHalt);

    // Write-back: ALU result in execute, load data on memory completion
    assign regWrite = ((state == stExecute) && writesReg)
                   || ((state == stMemory) && isLoad && !waitRequest);
    assign regWriteData = (state == stMemory) ? loadValue : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc <= resetVector;
            branchPending <= 1'b0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                stFetch: begin
                    if (pc == '0) begin
                        state <= stHalt; // No read for address zero
                    end else if (started && !waitRequest) begin
                        instrReg <= readData;
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    if (isLoad || isStore) begin
                        memAddr <= aluResult; // rs + immediate
                        state <= stMemory;
                    end else begin
                        pc <= nextPc;
                        branchPending <= takeBranch; // Target waits for the slot
                        pendingTarget <= target;
                        state <= stFetch;
                    end
                end
                stMemory: begin
                    if (!waitRequest) begin
                        pc <= nextPc;
                        branchPending <= 1'b0;
                        state <= stFetch;
                    end
                end
                default: state <= stHalt; // Halt until reset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/mipsCpuBus.sv
// Top level of the multicycle CPU with its memory-mapped bus master
// Connects control, register file, ALU and load/store unit
`timescale 1ns/1ps
`default_nettype none

module mipsCpuBus import mipsPkg::*; #(
    parameter word_t resetVector = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      registerV0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitRequest,
    output word_t      writeData,
    output logic [3:0] byteEnable,
    input  word_t      readData
);

    // Register file side
    regAddr_t rsIndex, rtIndex, regWriteIndex;
    logic regWrite;
    word_t regWriteData, rsData, rtData;

    // ALU side
    aluOp_t aluOp;
    word_t aluOperandB, aluResult;
    logic [4:0] shamt;
    logic equal;

    // Load/store side
    memAccess_t access;
    word_t loadValue;

    cpuControl #(
        .resetVector(resetVector)
    ) control (
        .clk(clk),
        .reset(reset),
        .waitRequest(waitRequest),
        .readData(readData),
        .rsData(rsData),
        .rtData(rtData),
        .aluResult(aluResult),
        .equal(equal),
        .loadValue(loadValue),
        .rsIndex(rsIndex),
        .rtIndex(rtIndex),
        .regWrite(regWrite),
        .regWriteIndex(regWriteIndex),
        .regWriteData(regWriteData),
        .aluOp(aluOp),
        .aluOperandB(aluOperandB),
        .shamt(shamt),
        .access(access),
        .address(address),
        .read(read),
        .write(write),
        .active(active)
    );

    registerFile regs (
        .clk(clk),
        .reset(reset),
        .rsIndex(rsIndex),
        .rtIndex(rtIndex),
        .writeEnable(regWrite),
        .writeIndex(regWriteIndex),
        .writeData(regWriteData),
        .rsData(rsData),
        .rtData(rtData),
        .registerV0(registerV0)
    );

    mipsAlu alu (
        .aluOp(aluOp),
        .operandA(rsData), // rs is always the first operand
        .operandB(aluOperandB),
        .shamt(shamt),
        .result(aluResult),
        .equal(equal)
    );

    loadStoreUnit lsu (
        .access(access),
        .storeData(rtData),
        .readData(readData),
        .writeData(writeData),
        .byteEnable(byteEnable),
        .loadValue(loadValue)
    );

endmodule

`default_nettype wire

//--- verif/mipsCpu_chk.sv
// Bus protocol and halt checks for the CPU top level
// Bound into mipsCpuBus, failures counted in errorCount for the testbench
`timescale 1ns/1ps
`default_nettype none

module mipsCpuChk import mipsPkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       read,
    input logic       write,
    input logic       waitRequest,
    input word_t      address,
    input word_t      writeData,
    input logic [3:0] byteEnable,
    input memAccess_t access,
    input logic       active
);

    int errorCount = 0; // Read by the testbench

    // Strobes are exclusive
    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            errorCount = errorCount + 1;
            $error("read and write high in the same cycle");
        end

    // Stalled request holds its address and strobes
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitRequest |=> $stable(address) && $stable(read) && $stable(write))
        else begin
            errorCount = errorCount + 1;
            $error("request changed while waitRequest was high");
        end

    assert property (@(posedge clk) disable iff (reset)
        write && waitRequest |=> $stable(writeData) && $stable(byteEnable))
        else begin
            errorCount = errorCount + 1;
            $error("store data or byte enables changed while stalled");
        end

    // Byte store uses a single lane
    assert property (@(posedge clk) disable iff (reset)
        write && access.isByte |-> $onehot(byteEnable))
        else begin
            errorCount = errorCount + 1;
            $error("byte store did not enable exactly one lane");
        end

    // Halt is final, bus quiet
    assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write ##1 !active)
        else begin
            errorCount = errorCount + 1;
            $error("bus activity or restart after halt");
        end

endmodule

bind mipsCpuBus mipsCpuChk chk (
    .clk(clk),
    .reset(reset),
    .read(read),
    .write(write),
    .waitRequest(waitRequest),
    .address(address),
    .writeData(writeData),
    .byteEnable(byteEnable),
    .access(access),
    .active(active)
);

`default_nettype wire

//--- verif/mipsCpuTb.sv
// Testbench for the multicycle CPU: bus memory model with random waits,
// program image at the reset vector, data area at address zero
// Results checked at halt against values worked out from MIPS semantics
`timescale 1ns/1ps
`default_nettype none

module mipsCpuTb import mipsPkg::*; ();

    localparam word_t resetVector = 32'hBFC00000;
    localparam word_t swValue = 32'h8000A234; // Built by LUI/ORI, stored by SW
    localparam logic [7:0] sbValue = 8'hA5;   // Low byte of 0x1A5, top bit set

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic waitRequest = 1'b1;
    word_t readData = '0;
    logic active, write, read;
    word_t registerV0, address, writeData;
    logic [3:0] byteEnable;

    word_t progMem [0:63]; // 256 bytes at the reset vector
    word_t dataMem [0:15]; // 64 bytes at address zero
    logic [5:0] progLen = '0;
    logic [31:0] lcgState = 32'd27;
    logic firstSeen = 1'b0;
    logic inProgram, inData;

    mipsCpuBus UUT (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .write(write),
        .read(read),
        .waitRequest(waitRequest),
        .writeData(writeData),
        .byteEnable(byteEnable),
        .readData(readData)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic word_t fillWord(input word_t a);
        return {a[15:0], a[31:16]} ^ ~a;
    endfunction

    // Instruction encoders
    function automatic word_t rTypeWord(input int rs, input int rt, input int rd,
                                        input int sa, input funct_t fn);
        return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic word_t immWord(input opcode_t op, input int rs, input int rt,
                                      input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t jumpWord(input word_t target);
        return {opJ, target[27:2]}; // Top 4 bits come from the PC
    endfunction

    task automatic addInstr(input word_t instr);
        progMem[progLen] = instr;
        progLen = progLen + 6'd1;
    endtask

    task automatic stopWithFailure();
        $display("Test FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        assert (actual === expected) else begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stopWithFailure();
        end
    endtask

    // Reference result, one step per group of instructions
    function automatic word_t expectedV0();
        word_t t0, t1, t2, v0, cmp, sraVal;
        t0 = 32'hFFFFFFFB;
        t1 = swValue;
        t2 = t1 - t0;
        v0 = (t2 & t1) ^ t2;
        cmp = {31'b0, $signed(t1) < $signed(t0)} + {31'b0, t1 < v0}
            + {31'b0, $signed(v0) < -32'sd1} + {31'b0, t0 < 32'hFFFFFFFF};
        v0 = v0 + (cmp << 4);
        sraVal = $signed(t1) >>> 8;
        v0 = v0 + (sraVal ^ (t1 >> 12));
        v0 = v0 + {{24{sbValue[7]}}, sbValue} + {24'b0, sbValue}; // LB then LBU
        v0 = v0 ^ {t1[31:16], sbValue, t1[7:0]};                  // LW after SB
        return v0 + 32'd31; // Delay slots and fall-through markers 1+2+4+8+16
    endfunction

    assign inProgram = (address[31:8] == resetVector[31:8]);
    assign inData = (address[31:6] == '0);

    // Memory model, every request sees at least one wait
    always @(posedge clk) begin
        logic [31:0] rnd;
        if (reset) begin
            waitRequest <= 1'b1;
        end else begin
            if ((read || write) && !inProgram && !inData) begin
                $display("bus access outside the memory model, address %h", address);
                stopWithFailure();
            end
            if (write && !waitRequest && inData) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteEnable[b]) dataMem[address[5:2]][8*b +: 8] = writeData[8*b +: 8];
                end
            end
            if ((read || write) && waitRequest) begin
                rnd = nextRandom();
                readData <= inProgram ? progMem[address[7:2]] : dataMem[address[5:2]];
                waitRequest <= (rnd[17:16] == 2'b00); // Extra wait one time in four
            end else begin
                waitRequest <= 1'b1; // Idle or just completed
            end
        end
    end

    // Reset behavior, first request and checker status
    always @(negedge clk) begin
        if (reset) begin
            assert (read === 1'b0 && write === 1'b0) else begin
                $display("bus strobe high during reset at %0t", $time);
                stopWithFailure();
            end
        end else if (!firstSeen && (read || write)) begin
            firstSeen = 1'b1;
            assert (read && !write) else begin
                $display("first bus request after reset is not a read");
                stopWithFailure();
            end
            checkValue("address", address, resetVector);
        end
        if (UUT.chk.errorCount != 0) begin
            $display("bus protocol assertion failed at %0t", $time);
            stopWithFailure();
        end
    end

    initial begin
        int cycles;
        word_t expected;
        for (int i = 0; i < 64; i++) begin
            progMem[i] = fillWord(resetVector + {24'b0, i[5:0], 2'b00});
        end
        for (int i = 0; i < 16; i++) begin
            dataMem[i] = fillWord({26'b0, i[3:0], 2'b00});
        end
        // ALU group
        addInstr(immWord(opAddiu, 0, 8, -5));
        addInstr(immWord(opLui, 0, 9, 'h8000));
        addInstr(immWord(opOri, 9, 9, 'hA234)); // Top immediate bit set, zero-extended
        addInstr(rTypeWord(9, 8, 10, 0, fnSubu));
        addInstr(rTypeWord(10, 9, 11, 0, fnAnd));
        addInstr(rTypeWord(11, 10, 2, 0, fnXor));
        addInstr(rTypeWord(9, 8, 12, 0, fnSlt));
        addInstr(rTypeWord(9, 2, 13, 0, fnSltu)); // Negative vs small positive
        addInstr(immWord(opSlti, 2, 14, -1));     // Signed and unsigned orders differ
        addInstr(immWord(opSltiu, 8, 15, -1)); // Sign-extended, compared unsigned
        addInstr(rTypeWord(12, 13, 12, 0, fnAddu));
        addInstr(rTypeWord(12, 14, 12, 0, fnAddu));
        addInstr(rTypeWord(12, 15, 12, 0, fnAddu));
        addInstr(rTypeWord(0, 12, 12, 4, fnSll));
        addInstr(rTypeWord(2, 12, 2, 0, fnAddu));
        addInstr(rTypeWord(0, 9, 13, 8, fnSra));
        addInstr(rTypeWord(0, 9, 14, 12, fnSrl));
        addInstr(rTypeWord(13, 14, 13, 0, fnXor));
        addInstr(rTypeWord(2, 13, 2, 0, fnAddu));
        addInstr(immWord(opAddiu, 0, 0, 7));   // Lost, $zero stays zero
        addInstr(rTypeWord(2, 0, 2, 0, fnAddu));
        // Stores then loads
        addInstr(immWord(opSw, 0, 9, 16));
        addInstr(immWord(opAddiu, 0, 8, 'h1A5));
        addInstr(immWord(opSb, 0, 8, 17));     // Lane 1 of word 4
        addInstr(immWord(opSb, 0, 8, 23));     // Lane 3 of word 5
        addInstr(immWord(opLb, 0, 17, 17));
        addInstr(immWord(opLbu, 0, 18, 17));
        addInstr(immWord(opLw, 0, 19, 16));
        addInstr(rTypeWord(2, 17, 2, 0, fnAddu));
        addInstr(rTypeWord(2, 18, 2, 0, fnAddu));
        addInstr(rTypeWord(2, 19, 2, 0, fnXor));
        // Control flow, slot markers 1..16 and skipped markers 0x100 and up
        addInstr(immWord(opBeq, 0, 0, 2));     // Taken
        addInstr(immWord(opAddiu, 2, 2, 1));
        addInstr(immWord(opAddiu, 2, 2, 'h100));
        addInstr(immWord(opBne, 0, 0, 5));     // Not taken
        addInstr(immWord(opAddiu, 2, 2, 2));
        addInstr(immWord(opAddiu, 2, 2, 4));
        addInstr(jumpWord(resetVector + 32'd160)); // To word 40
        addInstr(immWord(opAddiu, 2, 2, 8));
        addInstr(immWord(opAddiu, 2, 2, 'h200));
        addInstr(rTypeWord(0, 0, 0, 0, fnJr)); // JR $zero halts after its slot
        addInstr(immWord(opAddiu, 2, 2, 16));
        addInstr(immWord(opAddiu, 2, 2, 'h400));

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (cycles = 0; cycles < 4000 && active !== 1'b0; cycles++) begin
            @(negedge clk);
        end
        if (active !== 1'b0) begin
            $display("timeout waiting for the CPU to halt");
            stopWithFailure();
        end
        repeat (10) @(negedge clk); // Quiet bus after halt, watched by the checker

        checkValue("registerV0", registerV0, expectedV0());
        for (int i = 0; i < 16; i++) begin
            expected = fillWord({26'b0, i[3:0], 2'b00});
            if (i == 4) begin
                expected = {swValue[31:16], sbValue, swValue[7:0]};
            end
            if (i == 5) begin
                expected[31:24] = sbValue;
            end
            checkValue($sformatf("dataMem[%0d]", i), dataMem[i], expected);
        end

        if (UUT.chk.errorCount == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("bus protocol assertions failed during the run");
            stopWithFailure();
        end
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/mipsPkg.sv
verilog/registerFile.sv
verilog/mipsAlu.sv
verilog/loadStoreUnit.sv
verilog/cpuControl.sv
verilog/mipsCpuBus.sv
verif/mipsCpu_chk.sv
verif/mipsCpuTb.sv

//--- run.sh
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mipsCpuTb \
    -f compile.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Error limit raised so the testbench sees checker failures and reports them
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
exit 0
